//--- filelist.f
src/aesFieldPkg.sv
src/keyLayoutPkg.sv
src/keyStageIf.sv
src/sboxRom.sv
src/roundKeyStage.sv
src/keyExpandTop.sv
test/keyExpand_props.sv
test/tbKeyExpand.sv

//--- run.sh
#!/bin/sh
# build and run the key expansion testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tbKeyExpand -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/VtbKeyExpand)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the run counts as passed only when the testbench printed its pass line
if printf '%s\n' "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

//--- src/aesFieldPkg.sv
`default_nettype none

// field-level types and helpers shared by the key schedule
package aesFieldPkg;

    typedef logic [7:0] aesByteT;

    // first byte sits in the most significant position
    typedef logic [31:0] aesWordT;

    // constant used by the first round, later rounds double it
    localparam aesByteT FirstRcon = 8'h01;

    // multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic aesByteT xtime(input aesByteT value);
        aesByteT shifted;
        shifted = {value[6:0], 1'b0};
        if (value[7]) begin
            return shifted ^ 8'h1b;
        end
        return shifted;
    endfunction

    // cyclic left rotation by one byte, a0 a1 a2 a3 becomes a1 a2 a3 a0
    function automatic aesWordT rotWord(input aesWordT value);
        return {value[23:0], value[31:24]};
    endfunction

endpackage

`default_nettype wire

//--- src/keyExpandTop.sv
`default_nettype none

// pipelined AES-128 key expansion, one new cipher key may enter per cycle
module keyExpandTop import keyLayoutPkg::*, aesFieldPkg::*;
#(
    parameter int NumRounds = DefaultRounds
) (
    input logic clk,
    input logic arstN,
    input logic keyValid,
    input logic [KeyBits-1:0] cipherKey,
    output logic expandedValid,
    output logic [NumRounds*KeyBits-1:0] expandedKey
);

    // link k feeds stage k, and the last link holds the finished schedule
    keyStageIf #(.NumRounds(NumRounds)) link [0:NumRounds] ();

    // the first stage samples the key straight from the inputs
    assign link[0].valid = keyValid;
    assign link[0].roundKey = cipherKey;
    assign link[0].rcon = FirstRcon;
    assign link[0].expanded = '0;

    for (genvar k = 0; k < NumRounds; k++) begin : gStage
        roundKeyStage stage (
            .clk(clk),
            .arstN(arstN),
            .prevLink(link[k]),
            .nextLink(link[k+1])
        );
    end

    // round 1 ends up in the top slice after the last shift
    assign expandedValid = link[NumRounds].valid;
    assign expandedKey = link[NumRounds].expanded;

endmodule

`default_nettype wire

//--- src/keyLayoutPkg.sv
`default_nettype none

// widths and the shared view of one round key
package keyLayoutPkg;

    import aesFieldPkg::*;

    localparam int KeyBits = 128;
    localparam int KeyWords = 4;

    // number of round keys produced for an AES-128 key
    localparam int DefaultRounds = 10;

    // the XOR chain works on words while the S-box lookups work on bytes,
    // index 0 is the most significant element in both views
    typedef union packed {
        aesWordT [0:KeyWords-1] words;
        aesByteT [0:KeyWords*4-1] bytes;
    } roundKeyT;

endpackage

`default_nettype wire

//--- src/keyStageIf.sv
`default_nettype none

// state of one key travelling from a round stage to the next
interface keyStageIf import keyLayoutPkg::*, aesFieldPkg::*;
#(
    parameter int NumRounds = DefaultRounds
);

    logic valid;
    roundKeyT roundKey;
    aesByteT rcon;

    // round keys gathered so far, the newest one in the lowest slice
    logic [NumRounds*KeyBits-1:0] expanded;

    modport up (
        output valid,
        output roundKey,
        output rcon,
        output expanded
    );

    modport down (
        input valid,
        input roundKey,
        input rcon,
        input expanded
    );

endinterface

`default_nettype wire

//--- src/roundKeyStage.sv
`default_nettype none

// one round of the key schedule with its own pipeline register
module roundKeyStage import keyLayoutPkg::*, aesFieldPkg::*; (
    input logic clk,
    input logic arstN,
    keyStageIf.down prevLink,
    keyStageIf.up nextLink
);

    // the accumulator width follows whatever round count the links carry
    localparam int AccBits = $bits(prevLink.expanded);

    aesWordT subWord;
    aesWordT gWord;
    roundKeyT newKey;

    // substitute the bytes of the last word of the previous key
    for (genvar i = 0; i < 4; i++) begin : gSbox
        sboxRom sbox (
            .addr(prevLink.roundKey.bytes[(KeyWords-1)*4+i]),
            .data(subWord[8*(3-i) +: 8])
        );
    end

    // substitution acts on each byte alone, so rotating after it gives
    // the same word as rotating first
    assign gWord = rotWord(subWord) ^ {prevLink.rcon, 24'h000000};

    always_comb begin
        newKey.words[0] = prevLink.roundKey.words[0] ^ gWord;
        for (int j = 1; j < KeyWords; j++) begin
            newKey.words[j] = newKey.words[j-1] ^ prevLink.roundKey.words[j];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            nextLink.valid <= 1'b0;
        end else begin
            nextLink.valid <= prevLink.valid;
        end
    end

    // payload follows the valid bit and needs no clearing
    always_ff @(posedge clk) begin
        nextLink.roundKey <= newKey;
        nextLink.rcon <= xtime(prevLink.rcon);
        // older round keys move up one slice and the new one enters at the bottom
        nextLink.expanded <= AccBits'({prevLink.expanded, newKey});
    end

endmodule

`default_nettype wire

//--- src/sboxRom.sv
`default_nettype none

// forward AES substitution box, purely combinational
module sboxRom import aesFieldPkg::*; (
    input aesByteT addr,
    output aesByteT data
);

    // one row of sixteen entries selected by the upper nibble
    aesByteT [0:15] row;

    always_comb begin
        case (addr[7:4])
            4'h0: row = 128'h637c777b_f26b6fc5_3001672b_fed7ab76;
            4'h1: row = 128'hca82c97d_fa5947f0_add4a2af_9ca472c0;
            4'h2: row = 128'hb7fd9326_363ff7cc_34a5e5f1_71d83115;
            4'h3: row = 128'h04c723c3_1896059a_071280e2_eb27b275;
            4'h4: row = 128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84;
            4'h5: row = 128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf;
            4'h6: row = 128'hd0efaafb_434d3385_45f9027f_503c9fa8;
            4'h7: row = 128'h51a3408f_929d38f5_bcb6da21_10fff3d2;
            4'h8: row = 128'hcd0c13ec_5f974417_c4a77e3d_645d1973;
            4'h9: row = 128'h60814fdc_222a9088_46eeb814_de5e0bdb;
            4'ha: row = 128'he0323a0a_4906245c_c2d3ac62_9195e479;
            4'hb: row = 128'he7c8376d_8dd54ea9_6c56f4ea_657aae08;
            4'hc: row = 128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a;
            4'hd: row = 128'h703eb566_4803f60e_613557b9_86c11d9e;
            4'he: row = 128'he1f89811_69d98e94_9b1e87e9_ce5528df;
            default: row = 128'h8ca1890d_bfe64268_41992d0f_b054bb16;
        endcase
    end

    // lower nibble picks the entry within the row
    assign data = row[addr[3:0]];

endmodule

`default_nettype wire

//--- test/keyExpand_cases.txt
# columns: case name, cipher key, expected round 1 key, expected round 10 key
# every key is 32 hex digits with the first byte on the left
fips197 2b7e151628aed2a6abf7158809cf4f3c a0fafe1788542cb123a339392a6c7605 d014f9a8c9ee2589e13f0cc8b6630ca6
fips197c1 000102030405060708090a0b0c0d0e0f d6aa74fdd2af72fadaa678f1d6ab76fe 13111d7fe3944a17f307a78b4d2b30c5
allZero 00000000000000000000000000000000 62636363626363636263636362636363 b4ef5bcb3e92e21123e951cf6f8f188e
allOnes ffffffffffffffffffffffffffffffff e8e9e9e917161616e8e9e9e917161616 d60a3588e472f07b82d2d7858cd7c326
kungFu 5468617473206d79204b756e67204675 e232fcf191129188b159e4e6d679a293 28fddef86da4244accc0a4fe3b316f26

//--- test/keyExpand_props.sv
`default_nettype none

// pipeline timing properties of the key expansion unit
module keyExpandProps import keyLayoutPkg::*;
#(
    parameter int NumRounds = DefaultRounds
) (
    input logic clk,
    input logic arstN,
    input logic keyValid,
    input logic expandedValid
);

    // valid registers clear asynchronously, so the output is quiet in reset
    quietInReset: assert property (@(posedge clk) !arstN |-> !expandedValid)
        else $error("expandedValid high while reset is active");

    // every accepted key leaves the last stage after exactly NumRounds edges
    keyCompletes: assert property (@(posedge clk) disable iff (!arstN)
        $past(keyValid, NumRounds) |-> expandedValid)
        else $error("key entered %0d cycles ago but expandedValid is low", NumRounds);

    noSpuriousPulse: assert property (@(posedge clk) disable iff (!arstN)
        expandedValid |-> $past(keyValid, NumRounds))
        else $error("expandedValid high without a key %0d cycles earlier", NumRounds);

endmodule

`default_nettype wire

//--- test/tbKeyExpand.sv
`default_nettype none

module tbKeyExpand import keyLayoutPkg::*;;

    logic clk;
    logic arstN;
    logic keyValid;
    logic [KeyBits-1:0] cipherKey;
    logic expandedValid;
    logic [DefaultRounds*KeyBits-1:0] expandedKey;

    int cycleCount = 0;
    int pulseCount = 0;
    int sentCount = 0;
    int mismatchCount = 0;
    int failCount = 0;

    // cases as read from the file
    string caseName[$];
    logic [KeyBits-1:0] caseKey[$];
    logic [KeyBits-1:0] caseRound1[$];
    logic [KeyBits-1:0] caseRound10[$];

    // keys in flight, in launch order
    string pendName[$];
    logic [KeyBits-1:0] pendKey[$];
    logic [KeyBits-1:0] pendRound1[$];
    logic [KeyBits-1:0] pendRound10[$];
    int pendLaunch[$];

    keyExpandTop dut (
        .clk(clk),
        .arstN(arstN),
        .keyValid(keyValid),
        .cipherKey(cipherKey),
        .expandedValid(expandedValid),
        .expandedKey(expandedKey)
    );

    bind keyExpandTop keyExpandProps #(.NumRounds(NumRounds)) props (
        .clk(clk),
        .arstN(arstN),
        .keyValid(keyValid),
        .expandedValid(expandedValid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic readCases();
        int fd;
        int count;
        string line;
        string name;
        logic [KeyBits-1:0] key;
        logic [KeyBits-1:0] round1;
        logic [KeyBits-1:0] round10;
        fd = $fopen("test/keyExpand_cases.txt", "r");
        if (fd == 0) begin
            failCount++;
            $display("could not open test/keyExpand_cases.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            count = $sscanf(line, "%s %h %h %h", name, key, round1, round10);
            if (count != 4) begin
                failCount++;
                $display("malformed line in cases file: %s", line);
                continue;
            end
            caseName.push_back(name);
            caseKey.push_back(key);
            caseRound1.push_back(round1);
            caseRound10.push_back(round10);
        end
        $fclose(fd);
    endtask

    // present one key for a single cycle and remember what it should produce
    task automatic sendCase(input int idx);
        cipherKey = caseKey[idx];
        keyValid = 1'b1;
        pendName.push_back(caseName[idx]);
        pendKey.push_back(caseKey[idx]);
        pendRound1.push_back(caseRound1[idx]);
        pendRound10.push_back(caseRound10[idx]);
        // the key is captured on the next rising edge
        pendLaunch.push_back(cycleCount + 1);
        sentCount++;
        @(negedge clk);
    endtask

    task automatic idleCycles(input int n);
        keyValid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic waitForResults(input int limit, input string phase);
        int waited;
        waited = 0;
        while (pendName.size() > 0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        assert (pendName.size() == 0) else begin
            failCount++;
            $display("timed out in %s phase with %0d keys still in flight",
                phase, pendName.size());
        end
    endtask

    // outputs settle after the rising edge, so they are read on the falling one
    always @(negedge clk) begin : monitor
        string name;
        logic [KeyBits-1:0] prevRound;
        logic [KeyBits-1:0] curRound;
        logic [KeyBits-1:0] round1;
        logic [KeyBits-1:0] round10;
        logic [31:0] expWord;
        logic [31:0] gotWord;
        int latency;
        if (expandedValid === 1'b1) begin
            pulseCount++;
            assert (pendName.size() > 0) else begin
                failCount++;
                $display("expandedValid pulsed at cycle %0d with no key in flight",
                    cycleCount);
            end
            if (pendName.size() > 0) begin
                name = pendName.pop_front();
                prevRound = pendKey.pop_front();
                round1 = pendRound1.pop_front();
                round10 = pendRound10.pop_front();
                // a level seen here is sampled by the next rising edge
                latency = cycleCount + 1 - pendLaunch.pop_front();
                assert (latency == DefaultRounds) else begin
                    mismatchCount++;
                    $display("mismatch %s latency: expected %0d actual %0d",
                        name, DefaultRounds, latency);
                end
                curRound = expandedKey[(DefaultRounds-1)*KeyBits +: KeyBits];
                assert (curRound == round1) else begin
                    mismatchCount++;
                    $display("mismatch %s round 1: expected %h actual %h",
                        name, round1, curRound);
                end
                curRound = expandedKey[KeyBits-1:0];
                assert (curRound == round10) else begin
                    mismatchCount++;
                    $display("mismatch %s round %0d: expected %h actual %h",
                        name, DefaultRounds, round10, curRound);
                end
                // each word is the one before it XOR the same word of the previous round
                for (int r = 1; r <= DefaultRounds; r++) begin
                    curRound = expandedKey[(DefaultRounds-r)*KeyBits +: KeyBits];
                    for (int j = 1; j < KeyWords; j++) begin
                        expWord = curRound[KeyBits-1-32*(j-1) -: 32]
                            ^ prevRound[KeyBits-1-32*j -: 32];
                        gotWord = curRound[KeyBits-1-32*j -: 32];
                        assert (gotWord == expWord) else begin
                            mismatchCount++;
                            $display("mismatch %s round %0d word %0d: expected %h actual %h",
                                name, r, j, expWord, gotWord);
                        end
                    end
                    prevRound = curRound;
                end
            end
        end
    end

    initial begin
        integer seed;
        int gap;
        seed = 32'h0541_0a62;
        arstN = 1'b0;
        keyValid = 1'b0;
        cipherKey = '0;
        readCases();
        assert (caseName.size() > 0) else begin
            failCount++;
            $display("no cases were read from the cases file");
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        // all keys on consecutive cycles
        for (int i = 0; i < caseName.size(); i++) begin
            sendCase(i);
        end
        idleCycles(0);
        waitForResults(4 * DefaultRounds + caseName.size(), "back-to-back");

        // same keys again with random idle gaps in between
        for (int i = 0; i < caseName.size(); i++) begin
            sendCase(i);
            gap = $unsigned($random(seed)) % 4;
            idleCycles(gap);
        end
        idleCycles(0);
        waitForResults(4 * DefaultRounds + 4 * caseName.size(), "gapped");

        // any late pulse would show up here
        idleCycles(2 * DefaultRounds);
        assert (pulseCount == sentCount) else begin
            mismatchCount++;
            $display("mismatch pulseCount: expected %0d actual %0d", sentCount, pulseCount);
        end

        $display("summary: %0d mismatches, %0d other errors", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
